// ==== hw/fma_pkg.sv ====
// Binary16 only; all widths below are fixed for that format and not meant to be changed
package fma_pkg;

  // ----------------------------
  // Format constants
  // ----------------------------
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int FP_WIDTH = 1 + EXP_BITS + MAN_BITS;
  localparam int BIAS     = 15;
  // Mantissa plus implicit bit
  localparam int PREC_BITS = MAN_BITS + 1;

  // ----------------------------
  // Datapath widths
  // ----------------------------
  // Internal sum holds 3p+4 bits
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;
  // Leading zeros are only searched in the lower 2p+3 bits
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int LZC_WIDTH       = 5;
  // Signed internal exponent, wide enough for every sum of biased exponents
  localparam int EXP_WIDTH       = EXP_BITS + 2;
  localparam int SHAMT_WIDTH     = 6;

  // Canonical quiet NaN keeps only the top mantissa bit
  localparam logic [MAN_BITS-1:0] QNAN_MAN = {1'b1, {(MAN_BITS-1){1'b0}}};

  // ----------------------------
  // Shared types
  // ----------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // RISC-V flag order, NV on top
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } roundmode_e;

  // op_mod turns these into FMSUB, FNMADD and SUB
  typedef enum logic [1:0] {
    FMADD,
    FNMSUB,
    ADD,
    MUL
  } operation_e;

endpackage

// ==== hw/fma_dec_if.sv ====
// Decode to execute link; an item moves only when valid and ready are both high
`timescale 1ns/100ps
interface fma_dec_if import fma_pkg::*; ();

  logic       valid;
  logic       ready;
  // Operands after the operation adjustment
  fp_t        op_a;
  fp_t        op_b;
  fp_t        op_c;
  fp_info_t   info_a;
  fp_info_t   info_b;
  fp_info_t   info_c;
  roundmode_e rnd_mode;
  // Bypass result for NaN and infinity cases
  logic       is_special;
  fp_t        special_result;
  status_t    special_status;

  modport dec (
    output valid, op_a, op_b, op_c, info_a, info_b, info_c,
    output rnd_mode, is_special, special_result, special_status,
    input  ready
  );

  modport exe (
    input  valid, op_a, op_b, op_c, info_a, info_b, info_c,
    input  rnd_mode, is_special, special_result, special_status,
    output ready
  );

endinterface

// ==== hw/fma_sum_if.sv ====
// Execute to result link; all fields come straight from the middle register
`timescale 1ns/100ps
interface fma_sum_if import fma_pkg::*; ();

  logic                        valid;
  logic                        ready;
  logic                        eff_sub;
  // Biased internal exponents
  logic signed [EXP_WIDTH-1:0] exp_prod;
  logic signed [EXP_WIDTH-1:0] exp_diff;
  logic signed [EXP_WIDTH-1:0] tent_exp;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  // Addend bits shifted out before the add
  logic                        sticky;
  logic [SUM_WIDTH-1:0]        sum;
  logic                        final_sign;
  roundmode_e                  rnd_mode;
  logic                        is_special;
  fp_t                         special_result;
  status_t                     special_status;

  modport exe (
    output valid, eff_sub, exp_prod, exp_diff, tent_exp, addend_shamt, sticky, sum,
    output final_sign, rnd_mode, is_special, special_result, special_status,
    input  ready
  );

  modport res (
    input  valid, eff_sub, exp_prod, exp_diff, tent_exp, addend_shamt, sticky, sum,
    input  final_sign, rnd_mode, is_special, special_result, special_status,
    output ready
  );

endinterface

// ==== hw/fma_rounding.sv ====
// Rounds a sign-magnitude value by one ulp at most; an exponent carry is left to the caller
`timescale 1ns/100ps
module fma_rounding import fma_pkg::*; (
  input  logic [EXP_BITS+MAN_BITS-1:0] abs_value_i,
  input  logic                         sign_i,
  // Round bit on top, sticky below
  input  logic [1:0]                   round_sticky_i,
  input  roundmode_e                   rnd_mode_i,
  input  logic                         eff_sub_i,
  output logic [EXP_BITS+MAN_BITS-1:0] abs_rounded_o,
  output logic                         sign_o,
  output logic                         exact_zero_o
);

  logic round_up;

  always_comb begin
    unique case (rnd_mode_i)
      // Above half, or a tie on an odd value
      RNE: round_up = round_sticky_i[1] & (round_sticky_i[0] | abs_value_i[0]);
      RTZ: round_up = 1'b0;
      RDN: round_up = (|round_sticky_i) & sign_i;
      RUP: round_up = (|round_sticky_i) & ~sign_i;
      RMM: round_up = round_sticky_i[1];
      default: round_up = 1'b0;
    endcase
  end

  assign abs_rounded_o = abs_value_i + (EXP_BITS + MAN_BITS)'(round_up);
  assign exact_zero_o  = (abs_value_i == '0) && (round_sticky_i == 2'b00);
  // Exact cancellation gives -0 only when rounding down
  assign sign_o = (exact_zero_o && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;

endmodule

// ==== hw/fma_decode.sv ====
// Input stage; op_i must be one of the four legal operations, no flush and no NaN-boxing
`timescale 1ns/100ps
module fma_decode import fma_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  fp_t        a_i,
  input  fp_t        b_i,
  input  fp_t        c_i,
  input  roundmode_e rnd_mode_i,
  input  operation_e op_i,
  input  logic       op_mod_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  fma_dec_if.dec     dec
);

  fp_t        a_q, b_q, c_q;
  roundmode_e rnd_mode_q;
  operation_e op_q;
  logic       op_mod_q;
  logic       valid_q;
  logic       any_inf, any_nan, any_snan;
  logic       eff_sub;

  // Sign, exponent and mantissa decode of one operand
  function automatic fp_info_t classify(input fp_t op);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (op.exponent == '0);
    exp_ones           = (op.exponent == '1);
    man_zero           = (op.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit clear marks a signalling NaN
    info.is_signalling = info.is_nan && !op.mantissa[MAN_BITS-1];
    return info;
  endfunction

  // ----------------------------
  // Input register
  // ----------------------------
  // Free when empty or when execute takes the item
  assign in_ready_o = dec.ready | ~valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_ready_o && in_valid_i) begin
      a_q        <= a_i;
      b_q        <= b_i;
      c_q        <= c_i;
      rnd_mode_q <= rnd_mode_i;
      op_q       <= op_i;
      op_mod_q   <= op_mod_i;
    end
  end

  assign dec.valid    = valid_q;
  assign dec.rnd_mode = rnd_mode_q;

  // ----------------------------
  // Operation adjustment
  // ----------------------------
  always_comb begin
    dec.op_a   = a_q;
    dec.op_b   = b_q;
    dec.op_c   = c_q;
    dec.info_a = classify(a_q);
    dec.info_b = classify(b_q);
    dec.info_c = classify(c_q);
    // op_mod always negates the addend
    dec.op_c.sign = c_q.sign ^ op_mod_q;
    unique case (op_q)
      FMADD: ;
      // Negated product
      FNMSUB: dec.op_a.sign = ~a_q.sign;
      ADD: begin
        dec.op_a   = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        dec.info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin
        // Zero addend, its sign picked by the rounding mode
        dec.op_c   = '{sign: (rnd_mode_q != RDN), exponent: '0, mantissa: '0};
        dec.info_c = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign any_inf  = dec.info_a.is_inf | dec.info_b.is_inf | dec.info_c.is_inf;
  assign any_nan  = dec.info_a.is_nan | dec.info_b.is_nan | dec.info_c.is_nan;
  assign any_snan = dec.info_a.is_signalling | dec.info_b.is_signalling
                  | dec.info_c.is_signalling;
  // Product and addend of opposite sign
  assign eff_sub  = dec.op_a.sign ^ dec.op_b.sign ^ dec.op_c.sign;

  // ----------------------------
  // Special cases
  // ----------------------------
  always_comb begin
    dec.special_result = '{sign: 1'b0, exponent: '1, mantissa: QNAN_MAN};
    dec.special_status = '0;
    dec.is_special     = 1'b0;
    // Inf times zero is invalid even with a quiet NaN addend
    if ((dec.info_a.is_inf && dec.info_b.is_zero) ||
        (dec.info_a.is_zero && dec.info_b.is_inf)) begin
      dec.is_special        = 1'b1;
      dec.special_status.NV = 1'b1;
    end else if (any_nan) begin
      dec.is_special        = 1'b1;
      dec.special_status.NV = any_snan;
    end else if (any_inf) begin
      dec.is_special = 1'b1;
      if ((dec.info_a.is_inf || dec.info_b.is_inf) && dec.info_c.is_inf && eff_sub) begin
        // Opposite infinities cancel
        dec.special_status.NV = 1'b1;
      end else if (dec.info_a.is_inf || dec.info_b.is_inf) begin
        dec.special_result = '{sign: dec.op_a.sign ^ dec.op_b.sign, exponent: '1, mantissa: '0};
      end else begin
        dec.special_result = '{sign: dec.op_c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

// ==== hw/fma_execute.sv ====
// Middle stage; exponents stay biased, the sum is a magnitude with the sign kept apart
`timescale 1ns/100ps
module fma_execute import fma_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  fma_dec_if.exe dec,
  fma_sum_if.exe sum
);

  logic signed [EXP_WIDTH-1:0] exp_a, exp_b, exp_c;
  logic signed [EXP_WIDTH-1:0] exp_addend, exp_product, exp_diff, tent_exp;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  logic [PREC_BITS-1:0]        man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0]      product;
  logic [SUM_WIDTH-1:0]        product_shifted, addend_after_shift, addend_shifted;
  logic [PREC_BITS-1:0]        addend_sticky_bits;
  logic                        sticky_before_add;
  logic                        eff_sub, tent_sign;
  logic [SUM_WIDTH:0]          sum_raw;
  logic [SUM_WIDTH-1:0]        sum_abs;
  logic                        final_sign;

  assign eff_sub   = dec.op_a.sign ^ dec.op_b.sign ^ dec.op_c.sign;
  // Guess the product sign first
  assign tent_sign = dec.op_a.sign ^ dec.op_b.sign;

  // ----------------------------
  // Exponent datapath
  // ----------------------------
  assign exp_a = $signed({{(EXP_WIDTH-EXP_BITS){1'b0}}, dec.op_a.exponent});
  assign exp_b = $signed({{(EXP_WIDTH-EXP_BITS){1'b0}}, dec.op_b.exponent});
  assign exp_c = $signed({{(EXP_WIDTH-EXP_BITS){1'b0}}, dec.op_c.exponent});

  // Subnormals and zero count as exponent 1
  assign exp_addend  = exp_c + EXP_WIDTH'(!dec.info_c.is_normal);
  // Zero product takes the smallest exponent
  assign exp_product = (dec.info_a.is_zero || dec.info_b.is_zero) ?
                       EXP_WIDTH'(2 - BIAS) :
                       EXP_WIDTH'(exp_a + EXP_WIDTH'(dec.info_a.is_subnormal) + exp_b
                                  + EXP_WIDTH'(dec.info_b.is_subnormal) - BIAS);
  assign exp_diff    = exp_addend - exp_product;
  assign tent_exp    = (exp_diff > 0) ? exp_addend : exp_product;

  always_comb begin
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      // Addend lands fully in the sticky bit
      addend_shamt = SHAMT_WIDTH'(3 * PREC_BITS + 4);
    end else if (exp_diff <= PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff);
    end else begin
      // Product only reaches the sticky bit
      addend_shamt = '0;
    end
  end

  // ----------------------------
  // Mantissa datapath
  // ----------------------------
  assign man_a = {dec.info_a.is_normal, dec.op_a.mantissa};
  assign man_b = {dec.info_b.is_normal, dec.op_b.mantissa};
  assign man_c = {dec.info_c.is_normal, dec.op_c.mantissa};

  assign product         = man_a * man_b;
  // Two low bits left free for round and sticky
  assign product_shifted = SUM_WIDTH'(product) << 2;

  // Addend starts above the sum, bits falling off the end turn into sticky
  assign {addend_after_shift, addend_sticky_bits} =
      {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky_before_add = |addend_sticky_bits;

  assign addend_shifted = eff_sub ? ~addend_after_shift : addend_after_shift;
  // Carry in completes the two's complement unless sticky bits were lost
  assign sum_raw = product_shifted + addend_shifted + SUM_WIDTH'(eff_sub & ~sticky_before_add);

  // No carry on a subtraction means a negative sum
  assign sum_abs    = (eff_sub && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0] :
                                                          sum_raw[SUM_WIDTH-1:0];
  assign final_sign = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;

  // ----------------------------
  // Middle register
  // ----------------------------
  assign dec.ready = sum.ready | ~sum.valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sum.valid <= 1'b0;
    end else if (dec.ready) begin
      sum.valid <= dec.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec.ready && dec.valid) begin
      sum.eff_sub        <= eff_sub;
      sum.exp_prod       <= exp_product;
      sum.exp_diff       <= exp_diff;
      sum.tent_exp       <= tent_exp;
      sum.addend_shamt   <= addend_shamt;
      sum.sticky         <= sticky_before_add;
      sum.sum            <= sum_abs;
      sum.final_sign     <= final_sign;
      sum.rnd_mode       <= dec.rnd_mode;
      sum.is_special     <= dec.is_special;
      sum.special_result <= dec.special_result;
      sum.special_status <= dec.special_status;
    end
  end

endmodule

// ==== hw/fma_result.sv ====
// Output stage; underflow is detected after rounding as RISC-V requires
`timescale 1ns/100ps
module fma_result import fma_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  fma_sum_if.res sum,
  output fp_t    result_o,
  output status_t status_o,
  output logic   out_valid_o,
  input  logic   out_ready_i
);

  logic [LOWER_SUM_WIDTH-1:0]   sum_lower;
  logic [LZC_WIDTH-1:0]         lzc_cnt;
  logic                         lzc_empty;
  logic signed [LZC_WIDTH:0]    lzc_sgn;
  logic [SHAMT_WIDTH-1:0]       norm_shamt;
  logic signed [EXP_WIDTH-1:0]  norm_exp, final_exp;
  logic [SUM_WIDTH:0]           sum_shifted;
  logic [PREC_BITS:0]           final_man;
  logic [2*PREC_BITS+2:0]       sum_sticky_bits;
  logic                         sticky_after_norm;
  logic                         of_before_round, of_after_round, uf_after_round, inexact;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs, rounded_abs;
  logic [1:0]                   round_sticky;
  logic                         rounded_sign;
  logic [FP_WIDTH-1:0]          regular_result;
  status_t                      regular_status;

  // ----------------------------
  // Leading-zero count
  // ----------------------------
  assign sum_lower = sum.sum[LOWER_SUM_WIDTH-1:0];

  always_comb begin
    lzc_cnt   = '0;
    lzc_empty = 1'b1;
    // First set bit from the top wins
    for (int i = LOWER_SUM_WIDTH - 1; i >= 0; i--) begin
      if (lzc_empty && sum_lower[i]) begin
        lzc_cnt   = LZC_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
        lzc_empty = 1'b0;
      end
    end
  end

  assign lzc_sgn = $signed({1'b0, lzc_cnt});

  // ----------------------------
  // Normalization
  // ----------------------------
  always_comb begin
    if ((sum.exp_diff <= 0) || (sum.eff_sub && (sum.exp_diff <= 2))) begin
      if ((sum.exp_prod - lzc_sgn + 1 >= 0) && !lzc_empty) begin
        // Undo the product offset and drop the counted zeros
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + lzc_cnt);
        norm_exp   = EXP_WIDTH'(sum.exp_prod - lzc_sgn + 1);
      end else begin
        // Subnormal, stop the shift at the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + sum.exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored
      norm_shamt = sum.addend_shamt;
      norm_exp   = sum.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, sum.sum} << norm_shamt;

  // Leading one may still sit one place off
  always_comb begin
    {final_man, sum_sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                    = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sum_sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                    = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man, sum_sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp                    = norm_exp - 1;
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after_norm = (|sum_sticky_bits) | sum.sticky;

  // ----------------------------
  // Rounding
  // ----------------------------
  assign of_before_round = (final_exp >= 2**EXP_BITS - 1);

  // Overflow saturates to the largest normal and forces round and sticky
  assign pre_round_abs = of_before_round ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}} :
                                           {final_exp[EXP_BITS-1:0], final_man[MAN_BITS:1]};
  assign round_sticky  = of_before_round ? 2'b11 : {final_man[0], sticky_after_norm};

  fma_rounding u_fma_rounding (
    .abs_value_i    (pre_round_abs),
    .sign_i         (sum.final_sign),
    .round_sticky_i (round_sticky),
    .rnd_mode_i     (sum.rnd_mode),
    .eff_sub_i      (sum.eff_sub),
    .abs_rounded_o  (rounded_abs),
    .sign_o         (rounded_sign),
    .exact_zero_o   ()
  );

  // Tiny after rounding, or rounded up only by the unbounded-exponent carry
  assign uf_after_round = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0) ||
      ((pre_round_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0) &&
       (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == EXP_BITS'(1)) &&
       ((round_sticky != 2'b11) ||
        (!sum_sticky_bits[2*MAN_BITS+4] && ((sum.rnd_mode == RNE) || (sum.rnd_mode == RMM)))));
  assign of_after_round = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);
  assign inexact        = (|round_sticky) | of_before_round | of_after_round;

  // UF needs a result that is both tiny and inexact
  assign regular_result = {rounded_sign, rounded_abs};
  assign regular_status = '{NV: 1'b0, DZ: 1'b0,
                            OF: of_before_round | of_after_round,
                            UF: uf_after_round & inexact,
                            NX: inexact};

  // ----------------------------
  // Output register
  // ----------------------------
  assign sum.ready = out_ready_i | ~out_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (sum.ready) begin
      out_valid_o <= sum.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sum.ready && sum.valid) begin
      result_o <= sum.is_special ? sum.special_result : fp_t'(regular_result);
      status_o <= sum.is_special ? sum.special_status : regular_status;
    end
  end

endmodule

// ==== hw/fma_top.sv ====
// Binary16 FMA, three register stages; results come back in order, one item per cycle
`timescale 1ns/100ps
module fma_top import fma_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  fp_t        a_i,
  input  fp_t        b_i,
  input  fp_t        c_i,
  input  roundmode_e rnd_mode_i,
  input  operation_e op_i,
  input  logic       op_mod_i,
  input  logic       in_valid_i,
  output logic       in_ready_o,
  output fp_t        result_o,
  output status_t    status_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  fma_dec_if dec_if ();
  fma_sum_if sum_if ();

  // Input register, classification and special cases
  fma_decode u_fma_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .a_i        (a_i),
    .b_i        (b_i),
    .c_i        (c_i),
    .rnd_mode_i (rnd_mode_i),
    .op_i       (op_i),
    .op_mod_i   (op_mod_i),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .dec        (dec_if.dec)
  );

  // Multiply, align and add
  fma_execute u_fma_execute (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .dec     (dec_if.exe),
    .sum     (sum_if.exe)
  );

  // Normalize, round, output register
  fma_result u_fma_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sum         (sum_if.res),
    .result_o    (result_o),
    .status_o    (status_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// Free-running 100 ns clock; reset is held low for the first 16 rising edges
`timescale 1ns/100ps
module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Release on a rising edge, as the DUT reset is synchronous
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== tb/tb_fma_top.sv ====
// Table-driven FMA test with random back-pressure; expected values are worked out by hand
`timescale 1ns/100ps
module tb_fma_top import fma_pkg::*; ();

  typedef struct packed {
    fp_t        a;
    fp_t        b;
    fp_t        c;
    operation_e op;
    logic       op_mod;
    roundmode_e rnd_mode;
    fp_t        exp_result;
    status_t    exp_status;
  } row_t;

  logic       clk, rst_n;
  fp_t        a, b, c;
  roundmode_e rnd_mode;
  operation_e op;
  logic       op_mod, in_valid, in_ready;
  fp_t        result;
  status_t    status;
  logic       out_valid, out_ready;

  row_t   rows[$];
  string  row_name[$];
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     row_errors;
  int     wd_cycles = 0;
  int     extra;
  int     seed_dummy;

  tb_clock_gen u_tb_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  fma_top u_fma_top (
    .clk_i(clk), .rst_n_i(rst_n), .a_i(a), .b_i(b), .c_i(c),
    .rnd_mode_i(rnd_mode), .op_i(op), .op_mod_i(op_mod),
    .in_valid_i(in_valid), .in_ready_o(in_ready),
    .result_o(result), .status_o(status),
    .out_valid_o(out_valid), .out_ready_i(out_ready)
  );

  // ----------------------------
  // Stimulus table
  // ----------------------------
  task automatic add_row(input string name, input fp_t ra, input fp_t rb, input fp_t rc,
                         input operation_e rop, input logic rmod, input roundmode_e rrm,
                         input fp_t res, input status_t st);
    row_t r;
    r = '{a: ra, b: rb, c: rc, op: rop, op_mod: rmod, rnd_mode: rrm,
          exp_result: res, exp_status: st};
    rows.push_back(r);
    row_name.push_back(name);
  endtask

  task automatic build_table();
    // Small integers, all exact
    add_row("fmadd 2*3+1",   16'h4000, 16'h4200, 16'h3C00, FMADD,  1'b0, RNE, 16'h4700, 5'b00000);
    add_row("fmsub 2*3-1",   16'h4000, 16'h4200, 16'h3C00, FMADD,  1'b1, RNE, 16'h4500, 5'b00000);
    add_row("fnmsub -2*3+1", 16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b0, RNE, 16'hC500, 5'b00000);
    add_row("fnmadd -2*3-1", 16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b1, RNE, 16'hC700, 5'b00000);
    // ADD and SUB take the operands from b and c
    add_row("add 1.5+2.5",   16'h0000, 16'h3E00, 16'h4100, ADD,    1'b0, RNE, 16'h4400, 5'b00000);
    add_row("sub 1-3",       16'h0000, 16'h3C00, 16'h4200, ADD,    1'b1, RNE, 16'hC000, 5'b00000);
    add_row("mul 3*-2",      16'h4200, 16'hC000, 16'h0000, MUL,    1'b0, RNE, 16'hC600, 5'b00000);
    // NaN and infinity cases, canonical qNaN is 0x7E00
    add_row("inf*0+1",       16'h7C00, 16'h0000, 16'h3C00, FMADD,  1'b0, RNE, 16'h7E00, 5'b10000);
    add_row("snan operand",  16'h7C01, 16'h3C00, 16'h3C00, FMADD,  1'b0, RNE, 16'h7E00, 5'b10000);
    add_row("qnan operand",  16'h7E00, 16'h3C00, 16'h3C00, FMADD,  1'b0, RNE, 16'h7E00, 5'b00000);
    add_row("inf*1-inf",     16'h7C00, 16'h3C00, 16'h7C00, FMADD,  1'b1, RNE, 16'h7E00, 5'b10000);
    add_row("-inf*2+5",      16'hFC00, 16'h4000, 16'h4500, FMADD,  1'b0, RNE, 16'hFC00, 5'b00000);
    add_row("1*1+inf",       16'h3C00, 16'h3C00, 16'h7C00, FMADD,  1'b0, RNE, 16'h7C00, 5'b00000);
    // Half-ulp of 1.0 is 2^-11, a tie
    add_row("tie rne",       16'h0000, 16'h3C00, 16'h1000, ADD,    1'b0, RNE, 16'h3C00, 5'b00001);
    add_row("tie rup",       16'h0000, 16'h3C00, 16'h1000, ADD,    1'b0, RUP, 16'h3C01, 5'b00001);
    // 65504 is the largest normal
    add_row("ovf rne",       16'h7BFF, 16'h4000, 16'h0000, MUL,    1'b0, RNE, 16'h7C00, 5'b00101);
    add_row("ovf rtz",       16'h7BFF, 16'h4000, 16'h0000, MUL,    1'b0, RTZ, 16'h7BFF, 5'b00101);
    add_row("1-1 rne",       16'h0000, 16'h3C00, 16'h3C00, ADD,    1'b1, RNE, 16'h0000, 5'b00000);
    add_row("1-1 rdn",       16'h0000, 16'h3C00, 16'h3C00, ADD,    1'b1, RDN, 16'h8000, 5'b00000);
    add_row("mul 0*1 rne",   16'h0000, 16'h3C00, 16'h0000, MUL,    1'b0, RNE, 16'h0000, 5'b00000);
    add_row("mul 0*1 rdn",   16'h0000, 16'h3C00, 16'h0000, MUL,    1'b0, RDN, 16'h0000, 5'b00000);
    // 2^-14 * (1+2^-10)*2^-3 is 128.125 units of 2^-24, rounds to 0x0080
    add_row("uf inexact",    16'h0400, 16'h3001, 16'h0000, MUL,    1'b0, RNE, 16'h0080, 5'b00011);
    // 2^-14 * 0.5 is exactly 0x0200
    add_row("uf exact",      16'h0400, 16'h3800, 16'h0000, MUL,    1'b0, RNE, 16'h0200, 5'b00000);
  endtask

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic check_result(input fp_t got, input fp_t exp, input int row);
    if (got !== exp) begin
      $display("Fail at %0t: row %0d (%s) result %h, expected %h",
               $time, row, row_name[row], got, exp);
      row_errors++;
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp, input int row);
    if (got !== exp) begin
      $display("Fail at %0t: row %0d (%s) status %b, expected %b",
               $time, row, row_name[row], got, exp);
      row_errors++;
    end
  endtask

  // Applies the rows in order, a row stays until in_ready takes it
  task automatic drive_rows();
    int idx;
    idx = 0;
    while (idx < rows.size()) begin
      @(posedge clk);
      if (in_valid && in_ready) begin
        idx++;
      end
      if (idx < rows.size()) begin
        a        <= rows[idx].a;
        b        <= rows[idx].b;
        c        <= rows[idx].c;
        op       <= rows[idx].op;
        op_mod   <= rows[idx].op_mod;
        rnd_mode <= rows[idx].rnd_mode;
        in_valid <= 1'b1;
      end else begin
        in_valid <= 1'b0;
      end
    end
  endtask

  // Pops results in order and checks each against the next row
  task automatic collect_results();
    int idx;
    idx = 0;
    while (idx < rows.size()) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        row_errors = 0;
        check_result(result, rows[idx].exp_result, idx);
        check_status(status, rows[idx].exp_status, idx);
        if (row_errors == 0) begin
          $display("Test %0d (%s) ok", idx, row_name[idx]);
          pass_cnt++;
        end else begin
          fail_cnt++;
        end
        idx++;
      end
    end
  endtask

  // Random back-pressure on the output
  initial begin
    seed_dummy = $urandom(52);
    forever begin
      @(posedge clk);
      if (rst_n) begin
        out_ready <= ($urandom % 4) != 0;
      end
    end
  end

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    build_table();
    wd_cycles = rows.size() * 20 + 100;
    a         <= '0;
    b         <= '0;
    c         <= '0;
    op        <= FMADD;
    op_mod    <= 1'b0;
    rnd_mode  <= RNE;
    in_valid  <= 1'b0;
    out_ready <= 1'b0;
    @(posedge rst_n);
    @(negedge clk);
    // Pipeline must be empty and open after reset
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("Fail at %0t: after reset out_valid=%b in_ready=%b", $time, out_valid, in_ready);
      fail_cnt++;
    end else begin
      $display("Test reset state ok");
      pass_cnt++;
    end
    fork
      drive_rows();
      collect_results();
    join
    // Nothing may come out once every row is back
    extra = 0;
    repeat (8) begin
      @(posedge clk);
      if (out_valid && out_ready) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("Error: %0d unexpected extra results after the last row", extra);
      fail_cnt++;
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles + 16) @(posedge clk);
    $display("Error: the run timed out after %0d clock cycles", wd_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
hw/fma_pkg.sv
hw/fma_dec_if.sv
hw/fma_sum_if.sv
hw/fma_rounding.sv
hw/fma_decode.sv
hw/fma_execute.sv
hw/fma_result.sv
hw/fma_top.sv
tb/tb_clock_gen.sv
tb/tb_fma_top.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the binary16 FMA project
# Any variable can be overridden, e.g. make LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_fma_top
RTL_TOP   ?= fma_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS  := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
